//--- hw/team_12_settings.svh
/*
 * Team 12 PWM peripheral constants
 * Register map, bus page and PWM sizing shared by the RTL and the bench
 */
`ifndef TEAM_12_SETTINGS_SVH
`define TEAM_12_SETTINGS_SVH

// PWM sizing
`define PWM_WIDTH         16          // Counter, period and duty width
`define PWM_CHANNELS      4           // Channels, one enable bit each
`define GPIO_USABLE       34          // Pins 0 and 37:5

// Wishbone page of this block
`define TEAM_12_BASE      32'h3000_0000
`define TEAM_12_PAGE_MASK 32'hFFFF_0000   // Upper half selects the page

// Register offsets inside the page
`define REG_CTRL          16'h0000    // Bits 3:0 channel enables
`define REG_PERIOD        16'h0004
`define REG_DUTY0         16'h0008
`define REG_DUTY1         16'h000C
`define REG_DUTY2         16'h0010
`define REG_DUTY3         16'h0014
`define REG_GPIN_LO       16'h0018    // Synced gpio bits 31:0
`define REG_GPIN_HI       16'h001C    // Synced gpio bits 33:32

`endif

//--- hw/team_12_pkg.sv
/*
 * Team 12 shared types
 * Bus, PWM and GPIO vector types for the design and the bench
 */
`include "team_12_settings.svh"

package team_12_pkg;

    // Wishbone classic slave fields
    typedef logic [31:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_sel_t;    // One bit per byte lane

    // Count, period or duty value
    typedef logic [`PWM_WIDTH-1:0] pwm_val_t;

    // Usable pins, bit 0 is pin 0 and bits 33:1 are pins 37:5
    typedef logic [`GPIO_USABLE-1:0] gpio_vec_t;

endpackage

//--- hw/gpio_sync.sv
/*
 * GPIO input synchronizer
 * Two flop stages per usable pin
 */
`timescale 1ns/1ps

module gpio_sync
    import team_12_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  gpio_vec_t async_i,  // Straight from the pads
    output gpio_vec_t sync_o
);

    gpio_vec_t meta_q;          // First stage, may go metastable
    gpio_vec_t sync_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= async_i;
            sync_q <= meta_q;   // Settled copy
        end
    end

    assign sync_o = sync_q;

endmodule

//--- hw/pwm_channel.sv
/*
 * Single PWM channel
 * Duty is shadowed and taken at the period wrap, so a mid-cycle
 * update never cuts a pulse short; compare output is registered
 */
`timescale 1ns/1ps

module pwm_channel
    import team_12_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     en_i,
    input  pwm_val_t duty_i,
    input  pwm_val_t count_i,   // Shared period counter
    input  logic     wrap_i,    // Counter at its last value
    output logic     pwm_o
);

    pwm_val_t duty_sh_q;        // Duty in force this cycle
    logic     pwm_q;

    // Follows duty freely while disabled, else only at the wrap
    always_ff @(posedge clk_i) begin
        if (rst_i)
            duty_sh_q <= '0;
        else if (wrap_i || !en_i)
            duty_sh_q <= duty_i;
    end

    // High for counts below duty, one clock behind the counter
    always_ff @(posedge clk_i) begin
        if (rst_i)
            pwm_q <= 1'b0;
        else
            pwm_q <= en_i && (count_i < duty_sh_q);
    end

    assign pwm_o = pwm_q;

endmodule

//--- hw/team_12.sv
/*
 * Team 12 PWM core
 * Shared period counter feeding four PWM channels, plus the
 * GPIO input synchronizer and the pin and LA mapping
 */
`timescale 1ns/1ps
`include "team_12_settings.svh"

module team_12
    import team_12_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_i,

    // Registers from the bus wrapper
    input  logic [`PWM_CHANNELS-1:0] ctrl_en_i,
    input  pwm_val_t                 period_i,
    input  pwm_val_t                 duty0_i,
    input  pwm_val_t                 duty1_i,
    input  pwm_val_t                 duty2_i,
    input  pwm_val_t                 duty3_i,
    input  logic                     period_wr_i,   // Period register written

    // Pins
    input  gpio_vec_t                gpio_in_i,
    output gpio_vec_t                gpin_o,
    output gpio_vec_t                gpio_out_o,
    output gpio_vec_t                gpio_oeb_o,

    output logic [127:0]             la_data_out_o
);

    pwm_val_t                 count_q;
    logic                     wrap;
    pwm_val_t                 duty [`PWM_CHANNELS];
    logic [`PWM_CHANNELS-1:0] pwm;

    assign duty[0] = duty0_i;
    assign duty[1] = duty1_i;
    assign duty[2] = duty2_i;
    assign duty[3] = duty3_i;

    assign wrap = (count_q == period_i);    // Last count of the cycle

    // 0 to period inclusive, period+1 clocks per cycle
    always_ff @(posedge clk_i) begin
        if (rst_i || period_wr_i)
            count_q <= '0;                  // Fresh cycle on new period
        else if (wrap)
            count_q <= '0;
        else
            count_q <= count_q + 1'b1;
    end

    for (genvar ch = 0; ch < `PWM_CHANNELS; ch++) begin : g_ch
        pwm_channel u_pwm_channel (
            .clk_i   (clk_i),
            .rst_i   (rst_i),
            .en_i    (ctrl_en_i[ch]),
            .duty_i  (duty[ch]),
            .count_i (count_q),
            .wrap_i  (wrap),
            .pwm_o   (pwm[ch])
        );
    end

    gpio_sync u_gpio_sync (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .async_i (gpio_in_i),
        .sync_o  (gpin_o)
    );

    // Channels on vector bits 4:1, chip pins 8:5
    assign gpio_out_o = gpio_vec_t'({pwm, 1'b0});
    assign gpio_oeb_o = ~(gpio_vec_t'({`PWM_CHANNELS{1'b1}}) << 1);   // Others input

    assign la_data_out_o = 128'(pwm);       // Mirror for the analyzer

endmodule

//--- hw/team_12_wb.sv
/*
 * Team 12 Wishbone bus wrapper
 * Page and offset decode, byte-lane register writes, registered
 * read data and a single-cycle ack around the PWM core
 */
`timescale 1ns/1ps
`include "team_12_settings.svh"

module team_12_wb
    import team_12_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,

    // Wishbone slave
    input  wb_addr_t     adr_i,
    input  wb_data_t     dat_i,
    input  wb_sel_t      sel_i,
    input  logic         cyc_i,
    input  logic         stb_i,
    input  logic         we_i,
    output wb_data_t     dat_o,
    output logic         ack_o,

    // Logic analyzer
    input  logic [127:0] la_data_in_i,
    input  logic [127:0] la_oenb_i,
    output logic [127:0] la_data_out_o,

    // Usable GPIO pins
    input  gpio_vec_t    gpio_in_i,
    output gpio_vec_t    gpio_out_o,
    output gpio_vec_t    gpio_oeb_o
);

    logic                     req;          // cyc and stb both high
    logic                     ack_q;
    logic                     page_hit;
    logic [15:0]              reg_off;      // Offset inside the page
    logic                     wr_en;
    logic                     period_wr;
    logic [`PWM_CHANNELS-1:0] ctrl_en_q;
    pwm_val_t                 period_q;
    pwm_val_t                 duty_q [`PWM_CHANNELS];
    gpio_vec_t                gpin;         // Synced inputs from the core
    wb_data_t                 rd_val;
    wb_data_t                 wr_val;
    wb_data_t                 dat_q;

    // Replace only the enabled byte lanes
    function automatic wb_data_t byte_merge(input wb_data_t old_v,
                                            input wb_data_t new_v,
                                            input wb_sel_t  sel);
        wb_data_t res;
        res = old_v;
        for (int b = 0; b < 4; b++) begin
            if (sel[b])
                res[8*b +: 8] = new_v[8*b +: 8];
        end
        return res;
    endfunction

    assign req      = cyc_i & stb_i;
    assign page_hit = (adr_i & `TEAM_12_PAGE_MASK) == `TEAM_12_BASE;
    assign reg_off  = adr_i[15:0];

    // First cycle of a request only, ack_q blocks the second
    assign wr_en     = req & we_i & ~ack_q & page_hit;
    assign period_wr = wr_en && (reg_off == `REG_PERIOD);   // Restarts the counter

    // Current register value, zero off page or unmapped
    always_comb begin
        rd_val = '0;
        if (page_hit) begin
            case (reg_off)
                `REG_CTRL:    rd_val = wb_data_t'(ctrl_en_q);
                `REG_PERIOD:  rd_val = wb_data_t'(period_q);
                `REG_DUTY0:   rd_val = wb_data_t'(duty_q[0]);
                `REG_DUTY1:   rd_val = wb_data_t'(duty_q[1]);
                `REG_DUTY2:   rd_val = wb_data_t'(duty_q[2]);
                `REG_DUTY3:   rd_val = wb_data_t'(duty_q[3]);
                `REG_GPIN_LO: rd_val = gpin[31:0];
                `REG_GPIN_HI: rd_val = wb_data_t'(gpin[33:32]);
                default:      rd_val = '0;
            endcase
        end
    end

    assign wr_val = byte_merge(rd_val, dat_i, sel_i);  // Old value with new lanes

    // Control registers, truncated to implemented width
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ctrl_en_q <= '0;
            period_q  <= '0;
            for (int ch = 0; ch < `PWM_CHANNELS; ch++)
                duty_q[ch] <= '0;
        end else if (wr_en) begin
            case (reg_off)
                `REG_CTRL:   ctrl_en_q <= wr_val[`PWM_CHANNELS-1:0];
                `REG_PERIOD: period_q  <= wr_val[`PWM_WIDTH-1:0];
                `REG_DUTY0:  duty_q[0] <= wr_val[`PWM_WIDTH-1:0];
                `REG_DUTY1:  duty_q[1] <= wr_val[`PWM_WIDTH-1:0];
                `REG_DUTY2:  duty_q[2] <= wr_val[`PWM_WIDTH-1:0];
                `REG_DUTY3:  duty_q[3] <= wr_val[`PWM_WIDTH-1:0];
                default: ;                              // GPIN read only
            endcase
        end
    end

    // Single-cycle ack, then one idle cycle
    always_ff @(posedge clk_i) begin
        if (rst_i)
            ack_q <= 1'b0;
        else
            ack_q <= req & ~ack_q;
    end

    // Read data captured with the ack edge
    always_ff @(posedge clk_i) begin
        if (req && !ack_q)
            dat_q <= rd_val;
    end

    assign ack_o = ack_q;
    assign dat_o = dat_q;

    team_12 u_team_12 (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .ctrl_en_i     (ctrl_en_q),
        .period_i      (period_q),
        .duty0_i       (duty_q[0]),
        .duty1_i       (duty_q[1]),
        .duty2_i       (duty_q[2]),
        .duty3_i       (duty_q[3]),
        .period_wr_i   (period_wr),
        .gpio_in_i     (gpio_in_i),
        .gpin_o        (gpin),
        .gpio_out_o    (gpio_out_o),
        .gpio_oeb_o    (gpio_oeb_o),
        .la_data_out_o (la_data_out_o)
    );

endmodule

//--- hw/team_12_wrapper.sv
/*
 * Team 12 chip-facing wrapper
 * Ties off the bus master port and IRQs, keeps pins 4:1 as inputs
 * and hands the 34 usable pins to the Wishbone bus wrapper
 */
`timescale 1ns/1ps

module team_12_wrapper
    import team_12_pkg::*;
(
    // Wishbone slave
    input  logic         wb_clk_i,      // Management SoC clock
    input  logic         rst_i,
    input  logic         wbs_stb_i,
    input  logic         wbs_cyc_i,
    input  logic         wbs_we_i,
    input  wb_sel_t      wbs_sel_i,
    input  wb_data_t     wbs_dat_i,
    input  wb_addr_t     wbs_adr_i,
    output logic         wbs_ack_o,
    output wb_data_t     wbs_dat_o,

    // Logic analyzer
    input  logic [127:0] la_data_in_i,
    input  logic [127:0] la_oenb_i,
    output logic [127:0] la_data_out_o,

    // Chip pins
    input  logic [37:0]  gpio_in_i,
    output logic [37:0]  gpio_out_o,
    output logic [37:0]  gpio_oeb_o,    // Active low

    output logic [2:0]   irq_o,

    // Wishbone master, unused here
    output wb_addr_t     adr_o,
    output wb_data_t     dat_o,
    output wb_sel_t      sel_o,
    output logic         we_o,
    output logic         stb_o,
    output logic         cyc_o,
    input  wb_data_t     dat_i,
    input  logic         ack_i
);

    gpio_vec_t gpio_in_v;   // Usable pins only
    gpio_vec_t gpio_out_v;
    gpio_vec_t gpio_oeb_v;

    // Master port idle, arbiter never sees a request
    assign adr_o = '0;
    assign dat_o = '0;
    assign sel_o = '0;
    assign we_o  = 1'b0;
    assign stb_o = 1'b0;
    assign cyc_o = 1'b0;

    assign irq_o = 3'b000;  // No interrupts

    // Drop pins 4:1 from the usable vector
    assign gpio_in_v  = {gpio_in_i[37:5], gpio_in_i[0]};

    // Pins 4:1 kept as inputs driving zero
    assign gpio_out_o = {gpio_out_v[33:1], 4'b0000, gpio_out_v[0]};
    assign gpio_oeb_o = {gpio_oeb_v[33:1], 4'b1111, gpio_oeb_v[0]};

    team_12_wb u_team_12_wb (
        .clk_i         (wb_clk_i),
        .rst_i         (rst_i),
        .adr_i         (wbs_adr_i),
        .dat_i         (wbs_dat_i),
        .sel_i         (wbs_sel_i),
        .cyc_i         (wbs_cyc_i),
        .stb_i         (wbs_stb_i),
        .we_i          (wbs_we_i),
        .dat_o         (wbs_dat_o),
        .ack_o         (wbs_ack_o),
        .la_data_in_i  (la_data_in_i),
        .la_oenb_i     (la_oenb_i),
        .la_data_out_o (la_data_out_o),
        .gpio_in_i     (gpio_in_v),
        .gpio_out_o    (gpio_out_v),
        .gpio_oeb_o    (gpio_oeb_v)
    );

endmodule

//--- bench/team_12_tb_tasks.svh
/*
 * Testbench helpers
 * Random source, PWM reference model and error bookkeeping
 */
`ifndef TEAM_12_TB_TASKS_SVH
`define TEAM_12_TB_TASKS_SVH

logic [31:0] rng_state    = 32'h7c735982;   // xorshift32 state
int          value_errors = 0;              // Wrong values seen
int          bus_errors   = 0;              // Accesses never acked

// xorshift32 step
function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// High clocks in one complete PWM cycle of period+1 clocks
function automatic int expected_high(input pwm_val_t duty, input pwm_val_t period);
    int cycle_len;
    cycle_len = int'(period) + 1;
    if (int'(duty) < cycle_len)
        return int'(duty);
    return cycle_len;                       // Duty past the wrap saturates
endfunction

task automatic report_mismatch(input string msg);
    value_errors++;
    $display("mismatch at time %0t: %s", $time, msg);
endtask

`endif

//--- bench/team_12_tb.sv
/*
 * Team 12 PWM peripheral testbench
 * Drives the chip wrapper over Wishbone and checks registers, PWM duty,
 * glitch-free duty updates, channel disable and GPIO input capture
 */
`timescale 1ns/1ps
`include "team_12_settings.svh"

module team_12_tb
    import team_12_pkg::*;
();

    localparam int MAX_PERIOD  = 31;
    localparam int PWM_CYC     = MAX_PERIOD + 1;
    localparam int BUS_CYCLES  = 4;     // Request, ack, release, idle check
    localparam int ACK_LIMIT   = 16;
    localparam int REG_ROUNDS  = 30;
    localparam int PWM_ROUNDS  = 6;
    localparam int GPIO_ROUNDS = 6;
    localparam int WATCHDOG_CYCLES = 2
        + 8 * BUS_CYCLES                                 // Reset state
        + (2 * REG_ROUNDS + 12) * BUS_CYCLES             // Register access
        + PWM_ROUNDS * (7 * BUS_CYCLES + 3 * PWM_CYC)    // Duty counts
        + 7 * BUS_CYCLES + 20 + 6 * PWM_CYC              // Duty update
        + 4 * (2 * BUS_CYCLES + 3 * PWM_CYC)             // Disable
        + GPIO_ROUNDS * 2 * (5 + 2 * BUS_CYCLES)         // GPIO inputs
        + 500;                                           // Margin

    logic         clk;
    logic         rst_i;
    logic         wbs_stb_i;
    logic         wbs_cyc_i;
    logic         wbs_we_i;
    wb_sel_t      wbs_sel_i;
    wb_data_t     wbs_dat_i;
    wb_addr_t     wbs_adr_i;
    logic         wbs_ack_o;
    wb_data_t     wbs_dat_o;
    logic [127:0] la_data_in_i;
    logic [127:0] la_oenb_i;
    logic [127:0] la_data_out_o;
    logic [37:0]  gpio_in_i;
    logic [37:0]  gpio_out_o;
    logic [37:0]  gpio_oeb_o;
    logic [2:0]   irq_o;
    wb_addr_t     adr_o;
    wb_data_t     dat_o;
    wb_sel_t      sel_o;
    logic         we_o;
    logic         stb_o;
    logic         cyc_o;
    wb_data_t     dat_i;
    logic         ack_i;

    wb_data_t     reg_model [6];    // CTRL, PERIOD, DUTY0..3
    pwm_val_t     duty_set [4];     // Duties handed to program_pwm
    pwm_val_t     cur_period;
    int           high_cnt [4];

    `include "team_12_tb_tasks.svh"

    team_12_wrapper dut_i (
        .wb_clk_i (clk),
        .*
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;          // 100 ns period

    // Every clock outside reset
    ack_pulse: assert property (@(posedge clk) disable iff (rst_i) wbs_ack_o |=> !wbs_ack_o)
        else report_mismatch("ack held high for more than one cycle");
    la_mirror: assert property (@(posedge clk) disable iff (rst_i)
        la_data_out_o == {124'b0, gpio_out_o[8:5]})
        else report_mismatch("LA bits do not mirror the PWM pins");
    tie_offs: assert property (@(posedge clk) disable iff (rst_i)
        {adr_o, dat_o, sel_o, we_o, stb_o, cyc_o, irq_o} == '0
        && gpio_out_o[4:1] == 4'b0000 && gpio_oeb_o[4:1] == 4'b1111)
        else report_mismatch("master port, irq or pins 4:1 not tied off");

    function automatic wb_addr_t reg_addr(input int idx);
        case (idx)
            0:       return `TEAM_12_BASE + `REG_CTRL;
            1:       return `TEAM_12_BASE + `REG_PERIOD;
            2:       return `TEAM_12_BASE + `REG_DUTY0;
            3:       return `TEAM_12_BASE + `REG_DUTY1;
            4:       return `TEAM_12_BASE + `REG_DUTY2;
            5:       return `TEAM_12_BASE + `REG_DUTY3;
            6:       return `TEAM_12_BASE + `REG_GPIN_LO;
            default: return `TEAM_12_BASE + `REG_GPIN_HI;
        endcase
    endfunction

    // CTRL keeps one bit per channel
    function automatic wb_data_t reg_mask(input int idx);
        if (idx == 0)
            return (32'h1 << `PWM_CHANNELS) - 1;
        return (32'h1 << `PWM_WIDTH) - 1;
    endfunction

    // Each sel bit widened to a full byte of the lane mask
    function automatic wb_data_t merge_bytes(input wb_data_t old_v, input wb_data_t new_v,
                                             input wb_sel_t sel);
        wb_data_t lane_mask;
        lane_mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (old_v & ~lane_mask) | (new_v & lane_mask);
    endfunction

    // Pin 0 then pins 5 to 37 in order
    function automatic gpio_vec_t usable_pins(input logic [37:0] pins);
        gpio_vec_t v;
        v[0] = pins[0];
        for (int i = 1; i < 34; i++)
            v[i] = pins[i + 4];
        return v;
    endfunction

    // One classic access with rdata taken at the ack
    task automatic bus_access(input wb_addr_t addr, input logic we, input wb_data_t wdata,
                              input wb_sel_t sel, output wb_data_t rdata);
        int waited;
        waited = 0;
        rdata  = '0;
        @(posedge clk);
        wbs_cyc_i <= 1'b1;
        wbs_stb_i <= 1'b1;
        wbs_we_i  <= we;
        wbs_adr_i <= addr;
        wbs_dat_i <= wdata;
        wbs_sel_i <= sel;
        @(negedge clk);
        while (!wbs_ack_o && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (wbs_ack_o) begin
            rdata = wbs_dat_o;
            assert (waited == 1)
                else report_mismatch($sformatf("ack after %0d cycles at %h", waited, addr));
        end else begin
            bus_errors++;
            $display("no ack from the DUT for the access to address %h", addr);
        end
        @(posedge clk);
        wbs_cyc_i <= 1'b0;
        wbs_stb_i <= 1'b0;
        wbs_we_i  <= 1'b0;
        @(negedge clk);
        assert (!wbs_ack_o) else report_mismatch("ack lasted more than one cycle");
    endtask

    task automatic write_reg(input wb_addr_t addr, input wb_data_t data, input wb_sel_t sel);
        wb_data_t unused;
        bus_access(addr, 1'b1, data, sel, unused);
    endtask

    task automatic read_reg(input wb_addr_t addr, output wb_data_t data);
        bus_access(addr, 1'b0, '0, 4'hF, data);
    endtask

    // High clocks per pin over n clocks
    task automatic count_highs(input int n);
        for (int ch = 0; ch < 4; ch++)
            high_cnt[ch] = 0;
        repeat (n) begin
            @(negedge clk);
            for (int ch = 0; ch < 4; ch++)
                high_cnt[ch] += int'(gpio_out_o[5 + ch]);
            assert (la_data_out_o[3:0] == gpio_out_o[8:5])
                else report_mismatch("LA bits differ from the PWM pins");
        end
    endtask

    // Channels stay disabled while duties load so the shadows follow them
    task automatic program_pwm(input pwm_val_t period);
        cur_period = period;
        write_reg(reg_addr(0), 32'h0, 4'hF);
        for (int ch = 0; ch < 4; ch++)
            write_reg(reg_addr(2 + ch), 32'(duty_set[ch]), 4'hF);
        write_reg(reg_addr(1), 32'(period), 4'hF);   // Counter restarts
        write_reg(reg_addr(0), 32'hF, 4'hF);
    endtask

    task automatic check_reset_state();
        logic [37:0] exp_oeb;
        wb_data_t    rd;
        exp_oeb = '1;
        for (int pin = 5; pin <= 8; pin++)
            exp_oeb[pin] = 1'b0;                     // PWM pins only
        @(negedge clk);
        assert (!wbs_ack_o) else report_mismatch("ack high after reset");
        assert (gpio_out_o == '0 && la_data_out_o == '0)
            else report_mismatch($sformatf("pins %h LA %h after reset", gpio_out_o,
                                           la_data_out_o));
        assert (gpio_oeb_o == exp_oeb)
            else report_mismatch($sformatf("oeb %h, expected %h", gpio_oeb_o, exp_oeb));
        assert ({adr_o, dat_o, sel_o, we_o, stb_o, cyc_o, irq_o} == '0)
            else report_mismatch("master port or irq not zero after reset");
        for (int i = 0; i < 8; i++) begin
            read_reg(reg_addr(i), rd);
            assert (rd == '0) else report_mismatch($sformatf("reg %0d reads %h", i, rd));
        end
    endtask

    task automatic check_registers();
        int       idx;
        wb_data_t wdata;
        wb_sel_t  sel;
        wb_data_t rd;
        wb_addr_t bad [4];
        repeat (REG_ROUNDS) begin
            idx   = int'(next_rand() % 6);
            wdata = next_rand();
            sel   = wb_sel_t'(next_rand());
            reg_model[idx] = merge_bytes(reg_model[idx], wdata, sel) & reg_mask(idx);
            write_reg(reg_addr(idx), wdata, sel);
            read_reg(reg_addr(idx), rd);
            assert (rd == reg_model[idx])
                else report_mismatch($sformatf("reg %0d sel %b reads %h, expected %h",
                                               idx, sel, rd, reg_model[idx]));
        end
        bad = '{`TEAM_12_BASE + 32'h20, `TEAM_12_BASE + 32'hFFFC,
                `TEAM_12_BASE + 32'h1_0004, 32'h2000_0000};
        for (int i = 0; i < 4; i++) begin
            read_reg(bad[i], rd);
            assert (rd == '0) else report_mismatch($sformatf("%h reads %h", bad[i], rd));
        end
        write_reg(`TEAM_12_BASE + 32'h1_0004, 32'hFFFF_FFFF, 4'hF);   // PERIOD on wrong page
        for (int i = 0; i < 6; i++) begin
            read_reg(reg_addr(i), rd);
            assert (rd == reg_model[i])
                else report_mismatch($sformatf("reg %0d changed by off-page write", i));
        end
    endtask

    task automatic check_pwm_duty();
        pwm_val_t period;
        repeat (PWM_ROUNDS) begin
            period = pwm_val_t'(2 + next_rand() % (MAX_PERIOD - 1));
            for (int ch = 0; ch < 4; ch++)
                duty_set[ch] = pwm_val_t'(next_rand() % (period + 4));   // Some past the wrap
            program_pwm(period);
            repeat (2 * (period + 1)) @(negedge clk);
            count_highs(period + 1);
            for (int ch = 0; ch < 4; ch++)
                assert (high_cnt[ch] == expected_high(duty_set[ch], period))
                    else report_mismatch($sformatf("ch %0d period %0d duty %0d high %0d",
                                                   ch, period, duty_set[ch], high_cnt[ch]));
        end
    endtask

    // Complete high runs show the old duty and later only the new one
    task automatic check_duty_update();
        pwm_val_t period;
        pwm_val_t old_duty [4];
        pwm_val_t new_duty [4];
        int       run [4];
        logic     armed [4];        // Next run is whole once a low was seen
        logic     seen_new [4];
        int       off;
        period = pwm_val_t'(4 + next_rand() % (MAX_PERIOD - 3));
        for (int ch = 0; ch < 4; ch++) begin
            off          = 1 + int'(next_rand() % (period - 1));
            old_duty[ch] = pwm_val_t'(1 + next_rand() % period);          // Always a low gap
            new_duty[ch] = pwm_val_t'(1 + (old_duty[ch] - 1 + off) % period);
            duty_set[ch] = old_duty[ch];
            run[ch]      = 0;
            armed[ch]    = 1'b0;
            seen_new[ch] = 1'b0;
        end
        program_pwm(period);
        repeat (2 * (period + 1)) @(negedge clk);
        fork
            repeat (20 + 4 * (period + 1)) begin
                @(negedge clk);
                for (int ch = 0; ch < 4; ch++) begin
                    if (gpio_out_o[5 + ch]) begin
                        if (armed[ch])
                            run[ch]++;
                    end else begin
                        if (armed[ch] && run[ch] > 0) begin
                            assert (run[ch] == new_duty[ch]
                                    || (run[ch] == old_duty[ch] && !seen_new[ch]))
                                else report_mismatch($sformatf("ch %0d runt of %0d clocks",
                                                               ch, run[ch]));
                            if (run[ch] == new_duty[ch])
                                seen_new[ch] = 1'b1;
                        end
                        armed[ch] = 1'b1;
                        run[ch]   = 0;
                    end
                end
            end
            begin
                repeat ((period + 1) / 2) @(posedge clk);   // Lands mid-cycle
                for (int ch = 0; ch < 4; ch++)
                    write_reg(reg_addr(2 + ch), 32'(new_duty[ch]), 4'hF);
            end
        join
        for (int ch = 0; ch < 4; ch++) begin
            assert (seen_new[ch]) else report_mismatch($sformatf("ch %0d kept old duty", ch));
            duty_set[ch] = new_duty[ch];
        end
    endtask

    task automatic check_disable();
        int exp_cnt;
        for (int k = 0; k < 4; k++) begin
            write_reg(reg_addr(0), 32'(4'hF & ~(4'b1 << k)), 4'hF);
            assert (!gpio_out_o[5 + k])
                else report_mismatch($sformatf("ch %0d high two clocks after disable", k));
            count_highs(cur_period + 1);
            for (int ch = 0; ch < 4; ch++) begin
                exp_cnt = (ch == k) ? 0 : expected_high(duty_set[ch], cur_period);
                assert (high_cnt[ch] == exp_cnt)
                    else report_mismatch($sformatf("ch %0d high %0d, expected %0d, ch %0d off",
                                                   ch, high_cnt[ch], exp_cnt, k));
            end
            write_reg(reg_addr(0), 32'hF, 4'hF);
            repeat (2 * (cur_period + 1)) @(negedge clk);
        end
    endtask

    task automatic check_gpio_inputs();
        logic [37:0] pins;
        gpio_vec_t   exp_v;
        wb_data_t    lo;
        wb_data_t    hi;
        repeat (GPIO_ROUNDS) begin
            pins[31:0]  = next_rand();
            pins[37:32] = 6'(next_rand());
            for (int pass = 0; pass < 2; pass++) begin
                @(posedge clk);
                gpio_in_i <= pins;
                repeat (4) @(posedge clk);
                exp_v = usable_pins(pins);
                read_reg(reg_addr(6), lo);
                read_reg(reg_addr(7), hi);
                assert (lo == exp_v[31:0])
                    else report_mismatch($sformatf("GPIN_LO %h, expected %h", lo, exp_v[31:0]));
                assert (hi == {30'b0, exp_v[33:32]})
                    else report_mismatch($sformatf("GPIN_HI %h, expected %h", hi, exp_v[33:32]));
                pins[4:1] = ~pins[4:1];             // Reserved pins must not show up
            end
        end
    endtask

    initial begin
        rst_i        <= 1'b1;
        wbs_stb_i    <= 1'b0;
        wbs_cyc_i    <= 1'b0;
        wbs_we_i     <= 1'b0;
        wbs_sel_i    <= '0;
        wbs_dat_i    <= '0;
        wbs_adr_i    <= '0;
        la_data_in_i <= '0;
        la_oenb_i    <= '1;
        gpio_in_i    <= '0;
        dat_i        <= '0;
        ack_i        <= 1'b0;
        for (int i = 0; i < 6; i++)
            reg_model[i] = '0;
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        check_reset_state();
        check_registers();
        check_pwm_duty();
        check_duty_update();
        check_disable();
        check_gpio_inputs();
        $display("value errors: %0d, bus errors: %0d", value_errors, bus_errors);
        if (value_errors == 0 && bus_errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // Watchdog sized from the test loops above
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: tests still running after %0d clock cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- team_12.f
+incdir+hw
+incdir+bench
hw/team_12_pkg.sv
hw/gpio_sync.sv
hw/pwm_channel.sv
hw/team_12.sv
hw/team_12_wb.sv
hw/team_12_wrapper.sv
bench/team_12_tb.sv
